//--- sim.f
+incdir+include
source/fpFormatPkg.sv
source/cmpOpPkg.sv
source/alignIf.sv
source/operandPrealign.sv
source/mantissaAlign.sv
source/mantissaSubtract.sv
source/predicateDecide.sv
source/hcmpTop.sv
tb/tb_hcmpTop.sv

//--- Bender.yml
package:
  name: hcmp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/fpFormatPkg.sv
      - source/cmpOpPkg.sv
      - source/alignIf.sv
      - source/operandPrealign.sv
      - source/mantissaAlign.sv
      - source/mantissaSubtract.sv
      - source/predicateDecide.sv
      - source/hcmpTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_hcmpTop.sv

//--- tb/tb_hcmpTop.sv
`timescale 1ns/1ps
`include "hcmp_settings.svh"

module tb_hcmpTop;
	import fpFormatPkg::*;
	import cmpOpPkg::*;

	logic       clk;
	logic       rst;
	logic       ce;
	halfWord_t  a;
	halfWord_t  b;
	cmpOp_t     opcode;
	cmpResult_t result;

	cmpResult_t expPipe [0:`HCMP_PIPE_DEPTH-1]; // Slot 0 tracks stage 1, last slot is result
	int         errorCount;
	int         checkCount;

	hcmpTop UUT (
		.clk(clk), .rst(rst), .ce(ce), .a(a), .b(b), .opcode(opcode), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
	end

	// Reference decision from plain magnitude and sign compare
	function automatic cmpResult_t expectedBit(halfWord_t x, halfWord_t y, logic [4:0] code);
		logic nanX;
		logic nanY;
		logic eq;
		logic lt;
		logic gt;
		nanX = (&x[14:`HCMP_MAN_W]) && (x[`HCMP_MAN_W-1:0] != 0);
		nanY = (&y[14:`HCMP_MAN_W]) && (y[`HCMP_MAN_W-1:0] != 0);
		if (nanX || nanY)
			return code == 5'd8; // Only UNO holds
		eq = (x == y);
		lt = (x[15] & ~y[15]) | (~x[15] & ~y[15] & (x[14:0] < y[14:0]))
			| (x[15] & y[15] & (x[14:0] > y[14:0])); // Negative side is smaller
		gt = ~eq & ~lt;
		case (code)
			5'd2: return gt;
			5'd3: return gt | eq;
			5'd4: return lt;
			5'd5: return lt | eq;
			5'd6: return ~eq;
			5'd8: return 1'b0;
			default: return eq; // OEQ and unlisted codes
		endcase
	endfunction

	// Pipeline model, advances only on enabled edges
	always @(posedge clk) begin
		if (rst) begin
			expPipe[0] <= expectedBit('0, '0, '0); // Stage-1 zeros read as equal under OEQ
			for (int i = 1; i < `HCMP_PIPE_DEPTH; i++)
				expPipe[i] <= 1'b0;
		end else if (ce) begin
			expPipe[0] <= expectedBit(a, b, opcode);
			for (int i = 1; i < `HCMP_PIPE_DEPTH; i++)
				expPipe[i] <= expPipe[i-1];
		end
	end

	task automatic checkResult(input cmpResult_t got, input cmpResult_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t result got %0b expected %0b", $time, got, exp);
		end
	endtask

	task automatic finishRun(input string reason);
		if (reason != "")
			$display("Run aborted: %s", reason);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && reason == "")
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	// Looks at rst on clock edges only
	task automatic waitResetRelease(output bit released);
		int guard;
		guard = 0;
		do begin
			@(posedge clk);
			guard++;
		end while (rst && guard < 50);
		released = !rst;
	endtask

	function automatic halfWord_t randomHalf();
		halfExp_t e;
		e = 1 + ($urandom % 31); // No zero or subnormal
		return {1'($urandom), e, halfMan_t'($urandom)};
	endfunction

	// Mix of random, copied, sign-flipped, Inf and NaN operands
	task automatic pickOperands();
		int mode;
		mode = $urandom % 10;
		a = randomHalf();
		b = randomHalf();
		case (mode)
			0: b = a;
			1: b = a ^ 16'h8000;
			2: a = {a[15], 5'h1f, 10'h000}; // Infinity
			3: b = {b[15], 5'h1f, halfMan_t'(1 + ($urandom % 1023))}; // NaN
			4: b = {b[15], a[14:10], b[9:0]}; // Same exponent
			default: ;
		endcase
	endtask

	function automatic cmpOp_t pickOpcode(input bit allowUnknown);
		logic [4:0] codes [0:6];
		codes = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd8};
		if (allowUnknown && ($urandom % 4) == 0)
			return cmpOp_t'(5'($urandom)); // Any code, listed or not
		return cmpOp_t'(codes[$urandom % 7]);
	endfunction

	// Enabled edges push the last samples out to result
	task automatic drainPipeline();
		for (int i = 0; i < `HCMP_PIPE_DEPTH; i++) begin
			@(negedge clk);
			checkResult(result, expPipe[`HCMP_PIPE_DEPTH-1]);
			ce = 1'b1;
		end
		@(negedge clk);
		checkResult(result, expPipe[`HCMP_PIPE_DEPTH-1]);
	endtask

	initial begin
		bit released;
		errorCount = 0;
		checkCount = 0;
		void'($urandom(22));
		ce = 1'b0;
		a = '0;
		b = '0;
		opcode = OEQ;
		waitResetRelease(released);
		if (released) begin
			for (int i = 0; i < 1500; i++) begin
				@(negedge clk);
				checkResult(result, expPipe[`HCMP_PIPE_DEPTH-1]); // Stable between edges
				ce = (i < 500) ? 1'b1 : (($urandom % 3) != 0); // Stalls in the second half
				pickOperands();
				opcode = pickOpcode(i >= 1000);
			end
			drainPipeline();
			finishRun("");
		end else begin
			finishRun("reset was never released");
		end
	end

endmodule

//--- source/hcmpTop.sv
`timescale 1ns/1ps
`include "hcmp_settings.svh"

// Half-precision compare, four ce-qualified stages from input to result
module hcmpTop (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  fpFormatPkg::halfWord_t a,
	input  fpFormatPkg::halfWord_t b,
	input  cmpOpPkg::cmpOp_t       opcode,
	output cmpOpPkg::cmpResult_t   result
);
	import fpFormatPkg::*;
	import cmpOpPkg::*;

	logic                    signA;
	logic                    signB;
	logic [`HCMP_WORD_W-2:0] magA;
	logic [`HCMP_WORD_W-2:0] magB;
	expDiff_t                diffAB;
	expDiff_t                diffBA;
	logic                    unordered1; // From the input register
	cmpOp_t                  op1;
	logic                    isZero;
	logic                    isNeg;
	logic                    unordered3; // From the subtract register
	cmpOp_t                  op3;

	alignIf alignBus (); // Stage 2 registers

	operandPrealign prealign (
		.clk(clk), .rst(rst), .ce(ce), .a(a), .b(b), .opcode(opcode),
		.signA(signA), .signB(signB), .magA(magA), .magB(magB),
		.diffAB(diffAB), .diffBA(diffBA), .unordered(unordered1), .op(op1)
	);

	mantissaAlign align (
		.clk(clk), .rst(rst), .ce(ce),
		.signA(signA), .signB(signB), .magA(magA), .magB(magB),
		.diffAB(diffAB), .diffBA(diffBA), .unordered(unordered1), .op(op1),
		.alignOut(alignBus.producer)
	);

	mantissaSubtract subtract (
		.clk(clk), .rst(rst), .ce(ce), .alignIn(alignBus.consumer),
		.isZero(isZero), .isNeg(isNeg), .unordered(unordered3), .op(op3)
	);

	predicateDecide decide (
		.clk(clk), .rst(rst), .ce(ce), .isZero(isZero), .isNeg(isNeg),
		.unordered(unordered3), .op(op3), .result(result)
	);

endmodule

//--- source/predicateDecide.sv
`timescale 1ns/1ps

// Output stage
// Maps zero, sign and unordered onto the requested predicate
module predicateDecide (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  logic                   isZero,
	input  logic                   isNeg,
	input  logic                   unordered,
	input  cmpOpPkg::cmpOp_t       op,
	output cmpOpPkg::cmpResult_t   result
);
	import cmpOpPkg::*;

	logic       isEq;
	logic       isLt;
	logic       isGt;
	cmpResult_t decision;

	assign isEq = isZero;
	assign isLt = isNeg;
	assign isGt = ~isZero & ~isNeg; // Neither equal nor below

	always_comb begin
		if (unordered) begin
			decision = (op == UNO); // NaN fails every ordered test
		end else begin
			case (op)
				OGT: decision = isGt;
				OGE: decision = isGt | isEq;
				OLT: decision = isLt;
				OLE: decision = isLt | isEq;
				ONE: decision = ~isEq;
				UNO: decision = 1'b0;
				default: decision = isEq; // OEQ and unknown codes
			endcase
		end
	end

	// Held while ce is low
	always_ff @(posedge clk) begin
		if (rst)
			result <= 1'b0;
		else if (ce)
			result <= decision;
	end

endmodule

//--- source/mantissaSubtract.sv
`timescale 1ns/1ps
`include "hcmp_settings.svh"

// Stage 3
// Forms A - B on the aligned mantissas, keeps only zero and sign
module mantissaSubtract (
	input  logic             clk,
	input  logic             rst,
	input  logic             ce,
	alignIf.consumer         alignIn,
	output logic             isZero,
	output logic             isNeg,
	output logic             unordered,
	output cmpOpPkg::cmpOp_t op
);
	import fpFormatPkg::*;

	localparam int EXT_W = `HCMP_SUM_W - `HCMP_MAN_W - 2; // Extension bits below the LSB

	logic     effSub;
	mantSum_t maxExt;
	mantSum_t minExt;
	mantSum_t sum;
	logic     sumZero;
	logic     sumNeg;

	// B is negated, so equal signs mean a real subtract
	assign effSub = ~(alignIn.signA ^ alignIn.signB);

	assign maxExt = {1'b0, 1'b1, alignIn.maxMan, {EXT_W{1'b0}}}; // Carry, hidden bit, fraction
	assign minExt = {1'b0, alignIn.minMan, {EXT_W{1'b0}}};
	assign sum    = effSub ? maxExt - minExt : maxExt + minExt;

	// Zero only for equal magnitudes, a shifted minimum never reaches the hidden bit
	assign sumZero = ~|sum;
	// Sign of A - B follows the larger operand
	assign sumNeg  = ~sumZero & (alignIn.maxIsB ? ~alignIn.signB : alignIn.signA);

	always_ff @(posedge clk) begin
		if (rst) begin
			isZero    <= 1'b0;
			isNeg     <= 1'b0;
			unordered <= 1'b0;
			op        <= cmpOpPkg::cmpOp_t'(0);
		end else if (ce) begin
			isZero    <= sumZero;
			isNeg     <= sumNeg;
			unordered <= alignIn.unordered;
			op        <= alignIn.op;
		end
	end

endmodule

//--- source/mantissaAlign.sv
`timescale 1ns/1ps
`include "hcmp_settings.svh"

// Stage 2
// Picks the larger operand and right-shifts the smaller mantissa onto its exponent
module mantissaAlign (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ce,
	input  logic                    signA,
	input  logic                    signB,
	input  logic [`HCMP_WORD_W-2:0] magA,
	input  logic [`HCMP_WORD_W-2:0] magB,
	input  fpFormatPkg::expDiff_t   diffAB,
	input  fpFormatPkg::expDiff_t   diffBA,
	input  logic                    unordered,
	input  cmpOpPkg::cmpOp_t        op,
	alignIf.producer                alignOut
);
	import fpFormatPkg::*;
	import cmpOpPkg::*;

	logic        maxIsB;
	expDiff_t    shift;
	halfMan_t    maxMan;
	alignedMan_t minFull;   // Smaller mantissa with hidden bit
	alignedMan_t minCoarse; // After 0/4/8/12 step
	alignedMan_t minFine;   // After 0..3 step

	// Exponent sits above the fraction, so a plain compare orders magnitudes
	assign maxIsB = magA < magB;
	assign shift  = maxIsB ? diffBA : diffAB; // Never negative for the larger one
	assign maxMan = maxIsB ? magB[`HCMP_MAN_W-1:0] : magA[`HCMP_MAN_W-1:0];
	assign minFull = {1'b1, maxIsB ? magA[`HCMP_MAN_W-1:0] : magB[`HCMP_MAN_W-1:0]};

	// Coarse level
	always_comb begin
		if (shift[`HCMP_EXP_W-1]) begin
			minCoarse = '0; // 16 or more shifts everything out
		end else begin
			case (shift[3:2])
				2'd0: minCoarse = minFull;
				2'd1: minCoarse = minFull >> 4;
				2'd2: minCoarse = minFull >> 8;
				default: minCoarse = minFull >> 12; // Wider than the mantissa
			endcase
		end
	end

	// Fine level
	always_comb begin
		case (shift[1:0])
			2'd0: minFine = minCoarse;
			2'd1: minFine = minCoarse >> 1;
			2'd2: minFine = minCoarse >> 2;
			default: minFine = minCoarse >> 3;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			alignOut.signA     <= 1'b0;
			alignOut.signB     <= 1'b0;
			alignOut.maxIsB    <= 1'b0;
			alignOut.maxMan    <= '0;
			alignOut.minMan    <= '0;
			alignOut.unordered <= 1'b0;
			alignOut.op        <= cmpOp_t'(0);
		end else if (ce) begin
			alignOut.signA     <= signA;
			alignOut.signB     <= signB;
			alignOut.maxIsB    <= maxIsB;
			alignOut.maxMan    <= maxMan;
			alignOut.minMan    <= minFine;
			alignOut.unordered <= unordered;
			alignOut.op        <= op;
		end
	end

endmodule

//--- source/operandPrealign.sv
`timescale 1ns/1ps
`include "hcmp_settings.svh"

// Stage 1
// Input register, NaN detect and both exponent differences
module operandPrealign (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,
	input  fpFormatPkg::halfWord_t a,
	input  fpFormatPkg::halfWord_t b,
	input  cmpOpPkg::cmpOp_t      opcode,
	output logic                  signA,
	output logic                  signB,
	output logic [`HCMP_WORD_W-2:0] magA,
	output logic [`HCMP_WORD_W-2:0] magB,
	output fpFormatPkg::expDiff_t diffAB,
	output fpFormatPkg::expDiff_t diffBA,
	output logic                  unordered,
	output cmpOpPkg::cmpOp_t      op
);
	import fpFormatPkg::*;
	import cmpOpPkg::*;

	halfWord_t aReg;
	halfWord_t bReg;
	cmpOp_t    opReg;
	halfExp_t  expA;
	halfExp_t  expB;
	logic      nanA;
	logic      nanB;

	always_ff @(posedge clk) begin
		if (rst) begin
			aReg  <= '0;
			bReg  <= '0;
			opReg <= cmpOp_t'(0);
		end else if (ce) begin // Sample only on enabled edges
			aReg  <= a;
			bReg  <= b;
			opReg <= opcode;
		end
	end

	assign expA = aReg[`HCMP_WORD_W-2:`HCMP_MAN_W];
	assign expB = bReg[`HCMP_WORD_W-2:`HCMP_MAN_W];

	// All-ones exponent with a nonzero fraction
	assign nanA = (&expA) & (|aReg[`HCMP_MAN_W-1:0]);
	assign nanB = (&expB) & (|bReg[`HCMP_MAN_W-1:0]);

	// Add the inverted operand plus one, wraps when negative
	assign diffAB = expDiff_t'(expA + ~expB + 1'b1); // ExpA - ExpB
	assign diffBA = expDiff_t'(expB + ~expA + 1'b1); // ExpB - ExpA

	assign signA     = aReg[`HCMP_WORD_W-1];
	assign signB     = bReg[`HCMP_WORD_W-1];
	assign magA      = aReg[`HCMP_WORD_W-2:0]; // Exponent and fraction
	assign magB      = bReg[`HCMP_WORD_W-2:0];
	assign unordered = nanA | nanB;
	assign op        = opReg;

endmodule

//--- source/alignIf.sv
`timescale 1ns/1ps

// Aligned operands between the align and subtract stages
// Contents are registered, valid every cycle, change only on ce
interface alignIf;
	import fpFormatPkg::*;
	import cmpOpPkg::*;

	logic        signA;     // Sign of A
	logic        signB;     // Sign of B, not yet negated
	logic        maxIsB;    // B has the larger magnitude
	halfMan_t    maxMan;    // Larger mantissa, hidden bit implied
	alignedMan_t minMan;    // Smaller mantissa shifted to the larger exponent
	logic        unordered; // Either operand NaN
	cmpOp_t      op;        // Predicate travelling with the data

	modport producer (
		output signA, signB, maxIsB, maxMan, minMan, unordered, op
	);

	modport consumer (
		input signA, signB, maxIsB, maxMan, minMan, unordered, op
	);

endinterface

//--- source/cmpOpPkg.sv
`include "hcmp_settings.svh"

// Compare predicate codes and result
package cmpOpPkg;

	// Codes not listed here are decided as OEQ
	typedef enum logic [`HCMP_OP_W-1:0] {
		OEQ = `HCMP_OP_W'd1, // Ordered equal
		OGT = `HCMP_OP_W'd2, // Ordered greater
		OGE = `HCMP_OP_W'd3, // Ordered greater or equal
		OLT = `HCMP_OP_W'd4, // Ordered less
		OLE = `HCMP_OP_W'd5, // Ordered less or equal
		ONE = `HCMP_OP_W'd6, // Ordered not equal
		UNO = `HCMP_OP_W'd8  // Unordered, either side NaN
	} cmpOp_t;

	// Single predicate bit
	typedef logic cmpResult_t;

endpackage

//--- source/fpFormatPkg.sv
`include "hcmp_settings.svh"

// Half-precision number and the fields split out of it
package fpFormatPkg;

	// Whole value, sign on the MSB
	typedef logic [`HCMP_WORD_W-1:0] halfWord_t;

	// Biased exponent, all ones means Inf or NaN
	typedef logic [`HCMP_EXP_W-1:0] halfExp_t;

	// Stored fraction without the hidden bit
	typedef logic [`HCMP_MAN_W-1:0] halfMan_t;

	// Smaller mantissa after alignment, hidden bit included
	typedef logic [`HCMP_MAN_W:0] alignedMan_t;

	// Exponent difference, two's complement wraps
	typedef logic [`HCMP_EXP_W-1:0] expDiff_t;

	// Fixed-point sum or difference of the aligned mantissas
	typedef logic [`HCMP_SUM_W-1:0] mantSum_t;

endpackage

//--- include/hcmp_settings.svh
`ifndef HCMP_SETTINGS_SVH
`define HCMP_SETTINGS_SVH

// Half-precision field layout
`define HCMP_EXP_W 5   // Exponent field
`define HCMP_MAN_W 10  // Stored mantissa, hidden bit excluded
`define HCMP_WORD_W 16 // Sign + exponent + mantissa

// Fixed-point difference
// Hidden bit, mantissa, five extension bits and one carry
`define HCMP_SUM_W 17

// Registered stages from input sample to result
`define HCMP_PIPE_DEPTH 4

// Predicate code width
`define HCMP_OP_W 5

`endif
